/* hdl/board_pkg.sv */
//////////////////////////////////////////////////
// Shared widths, bit positions and bus structs of
// the arcade board-support block. Modules import it
// inside their bodies and use scoped names in ports.
//////////////////////////////////////////////////

package board_pkg;

    localparam int BOARD_JOY_W = 16;    // Raw joystick word from the board
    localparam int GAME_JOY_W  = 10;    // Joystick word seen by the game core
    localparam int OUT_COLOR_W = 8;     // Per channel, towards the scan doubler

    // Direction bits, common to board and game words
    localparam int JOY_RIGHT = 0;
    localparam int JOY_LEFT  = 1;
    localparam int JOY_DOWN  = 2;
    localparam int JOY_UP    = 3;

    // Shifted up by one when the game uses three buttons
    localparam int START1_BASE = 6;
    localparam int START2_BASE = 7;
    localparam int COIN_BASE   = 8;
    localparam int PAUSE_BASE  = 9;

    // Decoded keyboard state, all active high
    typedef struct packed {
        logic [GAME_JOY_W-1:0] joy1;
        logic [GAME_JOY_W-1:0] joy2;
        logic [1:0]            start;
        logic [1:0]            coin;
        logic                  reset;     // Soft reset key
        logic                  pause;
        logic                  service;
        logic [3:0]            gfx;       // Layer enable toggles
        logic [3:0]            vgactrl;
        logic                  rsvd;
    } key_state_t;

    // OSD status word, already laid out by the menu
    typedef struct packed {
        logic        flip;
        logic        rot_control;   // Screen rotated, swap directions
        logic        test;
        logic        pause_dip;
        logic [1:0]  fxlevel;
        logic [25:0] rsvd;
    } osd_status_t;

    typedef struct packed {
        logic [GAME_JOY_W-1:0] joy1;
        logic [GAME_JOY_W-1:0] joy2;
        logic [1:0]            coin;
        logic [1:0]            start;
        logic                  service;
    } game_inputs_t;

    typedef struct packed {
        logic [OUT_COLOR_W-1:0] r;
        logic [OUT_COLOR_W-1:0] g;
        logic [OUT_COLOR_W-1:0] b;
        logic                   hs;
        logic                   vs;
        logic                   de;   // High in the active picture
        logic                   cen;  // Pixel strobe aligned with the data
    } video_out_t;

endpackage

/* hdl/reset_seq.sv */
//////////////////////////////////////////////////
// Reset sequencer. Stretches the board reset into
// sys_rst and keeps a longer game_rst that restarts
// on download, reset request, soft reset or a flip
// setting change. Both outputs are registered.
//////////////////////////////////////////////////
`timescale 1ns/1ns

module reset_seq #(
    parameter int RST_STRETCH      = 32,
    parameter int GAME_RST_STRETCH = 64
) (
    input  logic clk_sys,
    input  logic rst,
    input  logic downloading,
    input  logic rst_req,
    input  logic soft_rst,
    input  logic dip_flip,
    output logic sys_rst,
    output logic game_rst
);

    localparam int SYS_CNT_W  = $clog2(RST_STRETCH + 1);
    localparam int GAME_CNT_W = $clog2(GAME_RST_STRETCH + 1);

    logic [SYS_CNT_W-1:0]  sys_cnt;
    logic [GAME_CNT_W-1:0] game_cnt;
    logic                  last_flip;
    logic                  flip_chg;
    logic                  game_trig;

    // Power-on stretch
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            sys_cnt <= '0;
            sys_rst <= 1'b1;
        end else if (sys_cnt != SYS_CNT_W'(RST_STRETCH)) begin
            sys_cnt <= sys_cnt + 1'b1;
            sys_rst <= 1'b1;
        end else begin
            sys_rst <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        last_flip <= dip_flip;   // Flipping the screen restarts the game
    end

    assign flip_chg  = last_flip != dip_flip;
    assign game_trig = sys_rst | downloading | rst_req | soft_rst | flip_chg;

    // Any trigger restarts the count
    always_ff @(posedge clk_sys) begin
        if (rst || game_trig) begin
            game_cnt <= '0;
            game_rst <= 1'b1;
        end else if (game_cnt != GAME_CNT_W'(GAME_RST_STRETCH)) begin
            game_cnt <= game_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end

endmodule

/* hdl/input_mapper.sv */
//////////////////////////////////////////////////
// Player input mapper. Syncs both board sticks,
// merges them with the decoded keys, swaps the
// directions on rotated screens and inverts all
// fields for active-low games. Two cycles of latency.
//////////////////////////////////////////////////
`timescale 1ns/1ns

module input_mapper #(
    parameter int THREE_BUTTONS = 0,
    parameter bit ACTIVE_LOW    = 1'b1
) (
    input  logic                              clk_sys,
    input  logic                              sys_rst,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joy1,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joy2,
    input  board_pkg::key_state_t             keys,
    input  logic                              rot_control,
    output board_pkg::game_inputs_t           game_in,
    output logic                              joy_pause
);
    import board_pkg::*;

    localparam int START1_BIT = START1_BASE + THREE_BUTTONS;
    localparam int START2_BIT = START2_BASE + THREE_BUTTONS;
    localparam int COIN_BIT   = COIN_BASE + THREE_BUTTONS;
    localparam int PAUSE_BIT  = PAUSE_BASE + THREE_BUTTONS;

    // Inactive level of every field, also the inversion mask
    localparam game_inputs_t IDLE = game_inputs_t'({$bits(game_inputs_t){ACTIVE_LOW}});

    logic [BOARD_JOY_W-1:0] joy1_sync;
    logic [BOARD_JOY_W-1:0] joy2_sync;
    key_state_t             keys_q;
    game_inputs_t           next_in;

    // Right/left and down/up trade places on a rotated screen
    function automatic logic [GAME_JOY_W-1:0] rotate_joy(
        input logic [GAME_JOY_W-1:0] joy,
        input logic                  rot
    );
        logic [GAME_JOY_W-1:0] swapped;
        swapped            = joy;
        swapped[JOY_RIGHT] = joy[JOY_LEFT];
        swapped[JOY_LEFT]  = joy[JOY_RIGHT];
        swapped[JOY_DOWN]  = joy[JOY_UP];
        swapped[JOY_UP]    = joy[JOY_DOWN];
        return rot ? swapped : joy;
    endfunction

    always_ff @(posedge clk_sys) begin
        joy1_sync <= board_joy1;
        joy2_sync <= board_joy2;
        keys_q    <= keys;
    end

    assign joy_pause = joy1_sync[PAUSE_BIT] | joy2_sync[PAUSE_BIT];

    always_comb begin
        next_in.joy1    = rotate_joy(joy1_sync[GAME_JOY_W-1:0] | keys_q.joy1, rot_control);
        next_in.joy2    = rotate_joy(joy2_sync[GAME_JOY_W-1:0] | keys_q.joy2, rot_control);
        next_in.coin    = {joy2_sync[COIN_BIT], joy1_sync[COIN_BIT]} | keys_q.coin;
        // Either stick may start either player
        next_in.start   = {joy1_sync[START2_BIT], joy1_sync[START1_BIT]}
                        | {joy2_sync[START2_BIT], joy2_sync[START1_BIT]}
                        | keys_q.start;
        next_in.service = keys_q.service;
    end

    always_ff @(posedge clk_sys) begin
        if (sys_rst) begin
            game_in <= IDLE;
        end else begin
            game_in <= next_in ^ IDLE;
        end
    end

endmodule

/* hdl/ctrl_toggles.sv */
//////////////////////////////////////////////////
// Control toggles. Rising key edges flip pause and
// the graphics and video enables; the reset key
// gives a one-cycle soft reset pulse.
//////////////////////////////////////////////////
`timescale 1ns/1ns

module ctrl_toggles (
    input  logic                  clk_sys,
    input  logic                  sys_rst,
    input  board_pkg::key_state_t keys,
    input  logic                  joy_pause,
    input  logic                  pause_dip,
    output logic                  game_pause,
    output logic [3:0]            gfx_en,
    output logic [3:0]            vgactrl_en,
    output logic                  soft_rst
);

    logic       last_pause;
    logic       last_joypause;
    logic       last_reset;
    logic [3:0] last_gfx;
    logic [3:0] last_vgactrl;
    logic       pause_rise;
    logic [3:0] gfx_rise;
    logic [3:0] vgactrl_rise;

    // Previous key levels for edge detection
    always_ff @(posedge clk_sys) begin
        last_pause    <= keys.pause;
        last_joypause <= joy_pause;
        last_reset    <= keys.reset;
        last_gfx      <= keys.gfx;
        last_vgactrl  <= keys.vgactrl;
    end

    assign pause_rise   = (keys.pause & ~last_pause) | (joy_pause & ~last_joypause);
    assign gfx_rise     = keys.gfx & ~last_gfx;
    assign vgactrl_rise = keys.vgactrl & ~last_vgactrl;

    always_ff @(posedge clk_sys) begin
        if (sys_rst) begin
            game_pause <= 1'b0;
            gfx_en     <= 4'hf;    // All layers on
            vgactrl_en <= 4'hf;
            soft_rst   <= 1'b0;
        end else begin
            if (pause_dip) begin
                game_pause <= 1'b1;    // DIP holds the game paused
            end else if (pause_rise) begin
                game_pause <= ~game_pause;
            end
            gfx_en     <= gfx_en ^ gfx_rise;
            vgactrl_en <= vgactrl_en ^ vgactrl_rise;
            soft_rst   <= keys.reset & ~last_reset;
        end
    end

endmodule

/* hdl/color_expand.sv */
//////////////////////////////////////////////////
// Video colour expander. Widens COLORW-bit game
// colour to 8 bits per channel by repeating the
// top bits, and registers it with syncs, de and
// the pixel strobe. One cycle of latency.
//////////////////////////////////////////////////
`timescale 1ns/1ns

module color_expand #(
    parameter int COLORW = 4    // 3 to 8
) (
    input  logic                  clk_sys,
    input  logic                  sys_rst,
    input  logic [COLORW-1:0]     game_r,
    input  logic [COLORW-1:0]     game_g,
    input  logic [COLORW-1:0]     game_b,
    input  logic                  lhbl,
    input  logic                  lvbl,
    input  logic                  hs,
    input  logic                  vs,
    input  logic                  pxl_cen,
    output board_pkg::video_out_t video
);
    import board_pkg::*;

    localparam int REPS = OUT_COLOR_W / COLORW + 1;   // Enough copies to fill 8 bits

    function automatic logic [OUT_COLOR_W-1:0] extend(input logic [COLORW-1:0] c);
        logic [REPS*COLORW-1:0] rep;
        rep = {REPS{c}};
        return rep[REPS*COLORW-1 -: OUT_COLOR_W];
    endfunction

    always_ff @(posedge clk_sys) begin
        video.r  <= extend(game_r);
        video.g  <= extend(game_g);
        video.b  <= extend(game_b);
        video.hs <= hs;
        video.vs <= vs;
        video.de <= lhbl & lvbl;    // Both blankings are active low
        // No pixel strobes towards the scan doubler during reset
        if (sys_rst) begin
            video.cen <= 1'b0;
        end else begin
            video.cen <= pxl_cen;
        end
    end

endmodule

/* hdl/board_top.sv */
//////////////////////////////////////////////////
// Board-support top level. Ties the reset
// sequencer, input mapper, control toggles and
// colour expander together on clk_sys. Game
// options are set through the parameters below.
//////////////////////////////////////////////////
`timescale 1ns/1ns

module board_top #(
    parameter int THREE_BUTTONS    = 0,
    parameter bit ACTIVE_LOW       = 1'b1,
    parameter int COLORW           = 4,
    parameter int RST_STRETCH      = 32,
    parameter int GAME_RST_STRETCH = 64
) (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joy1,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joy2,
    input  board_pkg::key_state_t             keys,
    input  board_pkg::osd_status_t            status,
    input  logic                              downloading,
    input  logic                              rst_req,
    input  logic [COLORW-1:0]                 game_r,
    input  logic [COLORW-1:0]                 game_g,
    input  logic [COLORW-1:0]                 game_b,
    input  logic                              lhbl,
    input  logic                              lvbl,
    input  logic                              hs,
    input  logic                              vs,
    input  logic                              pxl_cen,
    output logic                              sys_rst,
    output logic                              game_rst,
    output board_pkg::game_inputs_t           game_in,
    output logic                              game_pause,
    output logic [3:0]                        gfx_en,
    output logic [3:0]                        vgactrl_en,
    output logic                              dip_flip,
    output logic                              dip_test,
    output board_pkg::video_out_t             video
);

    logic joy_pause;    // Pause button on either stick
    logic soft_rst;

    assign dip_flip = status.flip;
    assign dip_test = status.test;

    reset_seq #(
        .RST_STRETCH      ( RST_STRETCH      ),
        .GAME_RST_STRETCH ( GAME_RST_STRETCH )
    ) u_reset_seq (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .rst_req     ( rst_req     ),
        .soft_rst    ( soft_rst    ),
        .dip_flip    ( dip_flip    ),
        .sys_rst     ( sys_rst     ),
        .game_rst    ( game_rst    )
    );

    input_mapper #(
        .THREE_BUTTONS ( THREE_BUTTONS ),
        .ACTIVE_LOW    ( ACTIVE_LOW    )
    ) u_input_mapper (
        .clk_sys     ( clk_sys            ),
        .sys_rst     ( sys_rst            ),
        .board_joy1  ( board_joy1         ),
        .board_joy2  ( board_joy2         ),
        .keys        ( keys               ),
        .rot_control ( status.rot_control ),
        .game_in     ( game_in            ),
        .joy_pause   ( joy_pause          )
    );

    ctrl_toggles u_ctrl_toggles (
        .clk_sys    ( clk_sys          ),
        .sys_rst    ( sys_rst          ),
        .keys       ( keys             ),
        .joy_pause  ( joy_pause        ),
        .pause_dip  ( status.pause_dip ),
        .game_pause ( game_pause       ),
        .gfx_en     ( gfx_en           ),
        .vgactrl_en ( vgactrl_en       ),
        .soft_rst   ( soft_rst         )
    );

    color_expand #(
        .COLORW ( COLORW )
    ) u_color_expand (
        .clk_sys ( clk_sys ),
        .sys_rst ( sys_rst ),
        .game_r  ( game_r  ),
        .game_g  ( game_g  ),
        .game_b  ( game_b  ),
        .lhbl    ( lhbl    ),
        .lvbl    ( lvbl    ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .pxl_cen ( pxl_cen ),
        .video   ( video   )
    );

endmodule

/* tests/board_props.sv */
//////////////////////////////////////////////////
// Concurrent assertions for the board-support top
// level, bound into board_top. They cover reset
// ordering, the gfx enables and de timing.
//////////////////////////////////////////////////
`timescale 1ns/1ns

module board_props (
    input logic                  clk_sys,
    input logic                  rst,
    input logic                  sys_rst,
    input logic                  game_rst,
    input logic [3:0]            gfx_en,
    input logic                  lhbl,
    input logic                  lvbl,
    input board_pkg::video_out_t video
);

    int fail_count = 0;

    // Game reset always covers the system reset
    sys_rst_in_game_rst: assert property (
        @(posedge clk_sys) disable iff (rst) sys_rst |-> game_rst
    ) else begin
        $error("sys_rst high while game_rst is low");
        fail_count++;
    end

    gfx_on_after_reset: assert property (
        @(posedge clk_sys) disable iff (rst) sys_rst |=> gfx_en == 4'hf
    ) else begin
        $error("gfx_en not all ones after sys_rst");
        fail_count++;
    end

    de_follows_blanking: assert property (
        @(posedge clk_sys) disable iff (rst) video.de == $past(lhbl & lvbl)
    ) else begin
        $error("video.de does not follow the blanking inputs");
        fail_count++;
    end

endmodule

bind board_top board_props u_props (.*);

/* tests/board_tb.sv */
//////////////////////////////////////////////////
// Testbench for the board-support top level.
// Plays the vectors of tests/board_tests.hex,
// holds each one for four clocks and compares the
// outputs on the last one. Bits the design ignores
// carry random noise.
//////////////////////////////////////////////////
`timescale 1ns/1ns

module board_tb;
    import board_pkg::*;

    localparam int CLK_PERIOD       = 40;
    localparam int RAND_SEED        = 13133;
    localparam int NUM_VECTORS      = 30;
    localparam int HOLD_CYCLES      = 4;
    localparam int TIMEOUT_CYCLES   = NUM_VECTORS * HOLD_CYCLES + 400;
    localparam int RST_STRETCH      = 32;    // Same as the board_top defaults
    localparam int GAME_RST_STRETCH = 64;

    // One line of the vector file, MSB first
    typedef struct packed {
        logic [7:0]  code;
        logic [15:0] joy1;
        logic [15:0] joy2;
        logic [35:0] keys;
        logic [3:0]  stat;       // flip, rot_control, test, pause_dip
        logic [11:0] color;      // r, g, b nibbles
        logic [3:0]  sync;       // lhbl, lvbl, hs, vs
        logic [3:0]  ctl;        // pxl_cen, downloading, rst_req, spare
        logic [3:0]  flags;      // check game_rst, its value, wait for fall, spare
        logic [27:0] exp_in;
        logic [3:0]  exp_pause;
        logic [3:0]  exp_gfx;
        logic [23:0] exp_rgb;
        logic [3:0]  exp_vid;    // hs, vs, de, cen
    } vector_t;

    logic                   clk_sys;
    logic                   rst;
    logic [BOARD_JOY_W-1:0] board_joy1;
    logic [BOARD_JOY_W-1:0] board_joy2;
    key_state_t             keys;
    osd_status_t            status;
    logic                   downloading;
    logic                   rst_req;
    logic [3:0]             game_r;
    logic [3:0]             game_g;
    logic [3:0]             game_b;
    logic                   lhbl;
    logic                   lvbl;
    logic                   hs;
    logic                   vs;
    logic                   pxl_cen;
    logic                   sys_rst;
    logic                   game_rst;
    game_inputs_t           game_in;
    logic                   game_pause;
    logic [3:0]             gfx_en;
    logic [3:0]             vgactrl_en;
    logic                   dip_flip;
    logic                   dip_test;
    video_out_t             video;

    logic [$bits(vector_t)-1:0] vec_mem [NUM_VECTORS];
    string                      cur_test;
    int                         cycles;
    logic [3:0]                 exp_vgactrl;         // Expected video-control enables
    logic [3:0]                 last_vgactrl_keys;

    board_top dut0 (.*);

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    // Cycle limit for the whole run
    initial begin
        cycles = 0;
        while (cycles <= TIMEOUT_CYCLES) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("Run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $fatal(1, "Timeout");
    end

    function automatic string test_name(input logic [7:0] code);
        case (code)
            8'h01:   return "joy_map";
            8'h02:   return "joy_rotate";
            8'h03:   return "toggles";
            8'h04:   return "pause_dip";
            8'h05:   return "soft_reset_key";
            8'h06:   return "reset_request";
            8'h07:   return "download";
            8'h08:   return "flip_change";
            8'h09:   return "colour";
            8'h0a:   return "reset_release";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: test %s, %s expected %0h, actual %0h",
                     cur_test, what, expected, actual);
            $display("Test failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s (test %s)", why, cur_test);
        $display("Test failed");
        $fatal(1, "Run aborted");
    endtask

    // Unused stick bits, keys.rsvd and the spare status bits get noise
    task automatic drive_vector(input vector_t v);
        logic [31:0] noise;
        noise       = $urandom();
        board_joy1  = {noise[31:26], v.joy1[9:0]};
        board_joy2  = {noise[5:0], v.joy2[9:0]};
        keys        = key_state_t'({v.keys[35:1], noise[28]});
        status      = osd_status_t'({v.stat, noise[27:0]});
        {game_r, game_g, game_b}       = v.color;
        {lhbl, lvbl, hs, vs}           = v.sync;
        {pxl_cen, downloading, rst_req} = v.ctl[3:1];
    endtask

    task automatic run_vector(input vector_t v);
        int waited;
        int cyc;
        cur_test = test_name(v.code);
        drive_vector(v);
        if (v.flags[1]) begin
            waited = 0;
            while (game_rst) begin
                @(posedge clk_sys);
                #2;
                waited++;
                if (waited > GAME_RST_STRETCH + 4) begin
                    abort_run("Game reset stayed high too long after its trigger");
                end
            end
        end
        for (cyc = 1; cyc <= HOLD_CYCLES; cyc++) begin
            @(posedge clk_sys);
            #2;
            if (cyc == 3 && v.flags[3] && v.flags[2]) begin
                check_value("game_rst rise", 1, game_rst);   // Up within 3 cycles
            end
        end
        // Each rising vgactrl key bit flips its enable
        exp_vgactrl       = exp_vgactrl ^ (v.keys[4:1] & ~last_vgactrl_keys);
        last_vgactrl_keys = v.keys[4:1];
        check_value("game_in", v.exp_in, game_in);
        check_value("game_pause", v.exp_pause[0], game_pause);
        check_value("gfx_en", v.exp_gfx, gfx_en);
        check_value("vgactrl_en", exp_vgactrl, vgactrl_en);
        check_value("video rgb", v.exp_rgb, {video.r, video.g, video.b});
        check_value("video hs/vs/de/cen", v.exp_vid, {video.hs, video.vs, video.de, video.cen});
        check_value("dip_flip", v.stat[3], dip_flip);
        check_value("dip_test", v.stat[1], dip_test);
        if (v.flags[3]) begin
            check_value("game_rst", v.flags[2], game_rst);
        end
        #3;    // Back to 5 ns after the edge
    endtask

    initial begin
        int waited;
        int i;
        void'($urandom(RAND_SEED));
        rst         = 1'b1;
        board_joy1  = '0;
        board_joy2  = '0;
        keys        = '0;
        status      = '0;
        downloading = 1'b0;
        rst_req     = 1'b0;
        {game_r, game_g, game_b} = '0;
        {lhbl, lvbl, hs, vs}     = '0;
        pxl_cen     = 1'b0;
        cur_test    = "reset";
        exp_vgactrl       = 4'hf;
        last_vgactrl_keys = 4'h0;
        $readmemh("tests/board_tests.hex", vec_mem);
        if ($isunknown(vec_mem[NUM_VECTORS-1])) begin
            abort_run("Vector file is missing or shorter than expected");
        end
        repeat (8) @(posedge clk_sys);
        #5;
        rst    = 1'b0;
        waited = 0;
        // Everything idle while the system reset is stretched
        while (sys_rst) begin
            check_value("game_in in reset", {$bits(game_inputs_t){1'b1}}, game_in);
            check_value("game_pause in reset", 0, game_pause);
            check_value("gfx_en in reset", 4'hf, gfx_en);
            check_value("vgactrl_en in reset", 4'hf, vgactrl_en);
            @(posedge clk_sys);
            #2;
            waited++;
            if (waited > RST_STRETCH + 2) begin
                abort_run("System reset did not fall in time");
            end
        end
        check_value("game_rst outlasts sys_rst", 1, game_rst);
        #3;
        for (i = 0; i < NUM_VECTORS; i++) begin
            run_vector(vector_t'(vec_mem[i]));
        end
        if (dut0.u_props.fail_count != 0) begin
            $display("%0d failures in the bound assertions", dut0.u_props.fail_count);
            $display("Test failed");
            $fatal(1, "Assertion failures");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

/* tests/board_tests.hex */
// code_joy1_joy2_keys_stat_rgb_sync_ctl_flags then expected game_in_pause_gfx_rgb_vid
// stat=flip,rot,test,pausedip sync=lhbl,lvbl,hs,vs ctl=cen,dl,rstreq flags=chk,grst,wait
01_0000_0000_000000000_0_5a3_c_8_0_1ffffff_0_f_55aa33_3
01_0009_0000_000000000_0_f09_5_0_0_1fb7fff_0_f_ff0099_4
01_0000_0004_008000200_0_7c1_e_8_0_1feff7e_0_f_77cc11_b
01_0100_0080_000006000_0_3e6_b_8_0_17fefe1_0_f_33ee66_d
01_0040_0140_000000000_0_5a3_c_8_0_1dfd7ed_0_f_55aa33_3
02_0001_0008_000000000_4_f09_5_0_0_1feff7f_0_f_ff0099_4
02_0002_0010_010000000_6_7c1_e_8_0_1fb7dff_0_f_77cc11_b
02_0000_0000_000090000_4_3e6_b_8_0_1ffff3f_0_f_33ee66_d
03_0000_0000_000000400_0_5a3_c_8_0_1ffffff_1_f_55aa33_3
03_0000_0000_000000000_0_f09_5_0_0_1ffffff_1_f_ff0099_4
03_0200_0000_000000000_0_7c1_e_8_0_0ffffff_0_f_77cc11_b
03_0000_0000_000000020_0_3e6_b_8_0_1ffffff_0_e_33ee66_d
03_0000_0000_000000042_0_5a3_c_8_0_1ffffff_0_c_55aa33_3
03_0000_0000_000000000_0_f09_5_0_0_1ffffff_0_c_ff0099_4
03_0000_0000_000000020_0_7c1_e_8_0_1ffffff_0_d_77cc11_b
04_0000_0000_000000000_1_3e6_b_8_0_1ffffff_1_d_33ee66_d
04_0000_0000_000000400_1_5a3_c_8_0_1ffffff_1_d_55aa33_3
04_0000_0000_000000400_0_f09_5_0_0_1ffffff_1_d_ff0099_4
04_0000_0000_000000000_0_7c1_e_8_8_1ffffff_1_d_77cc11_b
05_0000_0000_000000800_0_3e6_b_8_c_1ffffff_1_d_33ee66_d
0a_0000_0000_000000000_0_5a3_c_8_a_1ffffff_1_d_55aa33_3
06_0000_0000_000000000_0_f09_5_2_c_1ffffff_1_d_ff0099_4
0a_0000_0000_000000000_0_7c1_e_8_a_1ffffff_1_d_77cc11_b
07_0000_0000_000000000_0_3e6_b_c_c_1ffffff_1_d_33ee66_d
0a_0000_0000_000000000_0_5a3_c_8_a_1ffffff_1_d_55aa33_3
08_0000_0000_000000000_8_f09_5_0_c_1ffffff_1_d_ff0099_4
0a_0000_0000_000000000_8_7c1_e_8_a_1ffffff_1_d_77cc11_b
09_0000_0000_000000000_8_000_f_0_0_1ffffff_1_d_000000_e
09_0000_0000_000000000_8_fff_0_8_0_1ffffff_1_d_ffffff_1
09_0000_0000_000000000_8_9b2_6_8_8_1ffffff_1_d_99bb22_9

/* board.f */
hdl/board_pkg.sv
hdl/reset_seq.sv
hdl/input_mapper.sv
hdl/ctrl_toggles.sv
hdl/color_expand.sv
hdl/board_top.sv
tests/board_props.sv
tests/board_tb.sv

/* Bender.yml */
package:
  name: board

sources:
  - hdl/board_pkg.sv
  - hdl/reset_seq.sv
  - hdl/input_mapper.sv
  - hdl/ctrl_toggles.sv
  - hdl/color_expand.sv
  - hdl/board_top.sv
  - target: test
    files:
      - tests/board_props.sv
      - tests/board_tb.sv
